// ==== Makefile ====
# Verilator build and run for the DAC controller testbench

TOP := tb_dac_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass if the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f filelist.f -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
rtl/ad5676_pkg.sv
rtl/dac_cmd_pkg.sv
rtl/dac_ifs.sv
rtl/dac_cmd_sequencer.sv
rtl/dac_code_calc.sv
rtl/ad5676_spi_writer.sv
rtl/dac_ctrl_top.sv
testbench/dac_ctrl_props.sv
testbench/tb_dac_ctrl.sv

// ==== rtl/ad5676_pkg.sv ====
`default_nettype none

package ad5676_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // SPI frame layout
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [15:0] dac_code_t;  // Offset binary, midscale is zero
  typedef logic [2:0]  dac_chan_t;  // One of eight outputs
  typedef logic [23:0] spi_word_t;  // {cmd, 1'b0, channel, code}

  localparam int SPI_BITS = 24;
  localparam logic [3:0] SPI_CMD_WRITE = 4'b0001;  // Write input reg, held until LDAC

  localparam dac_code_t CODE_MIDSCALE  = 16'd32767;
  localparam dac_code_t CODE_FORBIDDEN = 16'hFFFF;  // No signed twin

  ////////////////////////////////////////////////////////////////////////////
  // Chip select timing
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_MHZ      = 20;
  localparam int T_UPDATE_NS  = 830;  // Min time between n_cs rising edges
  localparam int T_UPDATE_CYC = (T_UPDATE_NS * CLK_MHZ + 999) / 1000;  // Rounded up

  // High time between frames, the frame itself counts toward the update time
  localparam int CS_GAP_CYCLES =
    (T_UPDATE_CYC - SPI_BITS < 4)  ? 4 :
    (T_UPDATE_CYC - SPI_BITS > 31) ? 31 :
    T_UPDATE_CYC - SPI_BITS;

  function automatic spi_word_t spi_write_word(dac_chan_t ch, dac_code_t code);
    return {SPI_CMD_WRITE, 1'b0, ch, code};
  endfunction

endpackage

`default_nettype wire

// ==== rtl/ad5676_spi_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module ad5676_spi_writer
  import ad5676_pkg::*;
(
  input  wire        clk,
  input  wire        resetn,
  input  wire        in_error,  // Abort and park with n_cs high

  spi_pair_if.sink   spi,

  output logic       n_cs,
  output logic       mosi
);

  localparam int         SR_BITS  = 2 * SPI_BITS;
  localparam logic [4:0] GAP_LAST = 5'(CS_GAP_CYCLES - 1);
  localparam logic [4:0] BIT_LAST = 5'(SPI_BITS - 1);

  typedef enum logic [1:0] {
    W_IDLE,
    W_GAP,    // n_cs high, update time
    W_SHIFT   // n_cs low, one bit per clk
  } wr_state_e;

  wr_state_e          st;
  logic [4:0]         cnt;     // Gap cycles or frame bits left
  logic               second;  // word_b on the wire
  logic [SR_BITS-1:0] sreg;    // word_a in the upper half

  ////////////////////////////////////////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      st            <= W_IDLE;
      n_cs          <= 1'b1;
      mosi          <= 1'b0;  // Quiet between frames
      cnt           <= '0;
      second        <= 1'b0;
      spi.pair_done <= 1'b0;
    end else begin
      spi.pair_done <= 1'b0;
      case (st)
        W_IDLE: begin
          if (spi.start) begin
            st     <= W_GAP;
            cnt    <= GAP_LAST;
            second <= 1'b0;
          end
        end
        W_GAP: begin
          if (cnt == '0) begin
            st   <= W_SHIFT;
            n_cs <= 1'b0;
            mosi <= sreg[SR_BITS-1];  // First bit goes out with n_cs low
            cnt  <= BIT_LAST;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        W_SHIFT: begin
          if (cnt == '0) begin
            n_cs <= 1'b1;  // Rising edge latches the frame
            mosi <= 1'b0;
            if (second) begin
              st            <= W_IDLE;
              spi.pair_done <= 1'b1;
            end else begin
              st     <= W_GAP;
              second <= 1'b1;
              cnt    <= GAP_LAST;
            end
          end else begin
            mosi <= sreg[SR_BITS-2];  // Register moves on this same edge
            cnt  <= cnt - 1'b1;
          end
        end
        default: st <= W_IDLE;
      endcase
    end
  end

  // MSB first, both frames back to back in one register
  always_ff @(posedge clk) begin
    if (st == W_IDLE && spi.start) sreg <= {spi.word_a, spi.word_b};
    else if (st == W_SHIFT)        sreg <= {sreg[SR_BITS-2:0], 1'b0};
  end

endmodule

`default_nettype wire

// ==== rtl/dac_cmd_pkg.sv ====
`default_nettype none

package dac_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] cmd_word_t;

  // Opcode lives in bits 31:30
  typedef enum logic [1:0] {
    CMD_NO_OP   = 2'b00,
    CMD_DAC_WR  = 2'b01,
    CMD_SET_CAL = 2'b10,
    CMD_CANCEL  = 2'b11
  } cmd_op_e;

  localparam int TRIG_BIT = 29;  // Wait on triggers, not cycles
  localparam int CONT_BIT = 28;  // Next word must be ready at the end
  localparam int LDAC_BIT = 27;  // Pulse ldac on normal end

  typedef logic [25:0]        wait_cnt_t;  // Delay cycles or trigger count
  typedef logic signed [15:0] cal_val_t;   // Per-channel offset, two's complement

  localparam int PAIRS_PER_WRITE = 4;  // Pair words after a DAC_WR

  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_DAC_WR,
    S_ERROR
  } seq_state_e;

  // Field pickers
  function automatic cmd_op_e cmd_op(cmd_word_t w);
    return cmd_op_e'(w[31:30]);
  endfunction

  function automatic wait_cnt_t cmd_count(cmd_word_t w);
    return w[25:0];
  endfunction

  function automatic logic [2:0] cmd_cal_ch(cmd_word_t w);
    return w[18:16];
  endfunction

  function automatic cal_val_t cmd_cal_val(cmd_word_t w);
    return $signed(w[15:0]);
  endfunction

endpackage

`default_nettype wire

// ==== rtl/dac_cmd_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_cmd_sequencer
  import ad5676_pkg::*;
  import dac_cmd_pkg::*;
(
  input  wire             clk,
  input  wire             resetn,

  input  wire cmd_word_t  cmd_word,
  input  wire             cmd_buf_empty,
  output logic            cmd_word_rd_en,

  input  wire             trigger,
  output logic            waiting_for_trig,
  output logic            ldac,

  output logic            unexp_trig,
  output logic            cmd_buf_underflow,
  input  wire             err_in,  // Calculator flags

  output logic            cal_wr,
  output dac_chan_t       cal_ch,
  output cal_val_t        cal_val,

  dac_pair_if.source      pair,
  spi_pair_if.monitor     spi
);

  localparam logic [1:0] LAST_PAIR = 2'(PAIRS_PER_WRITE - 1);

  seq_state_e state;
  logic       do_ldac;    // Flags of the running command
  logic       trig_mode;
  logic       cont;
  wait_cnt_t  wait_cnt;   // Delay timer or trigger counter, never both at once
  logic [1:0] pair_idx;
  logic       pair_rd;    // Pop a pair word this cycle

  cmd_op_e op;
  logic    have_word;
  logic    halt;
  logic    go;
  logic    wait_done;
  logic    cancel;
  logic    fetch;
  logic    trig_err;
  logic    uf_err;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign op        = cmd_op(cmd_word);
  assign have_word = !cmd_buf_empty;
  assign halt      = (state == S_ERROR) || err_in;

  // Wait ends on the last delay cycle or the last trigger
  assign wait_done = ((state == S_DELAY) || (state == S_TRIG_WAIT && trigger))
                     && (wait_cnt == '0);
  assign cancel    = (state == S_DELAY || state == S_TRIG_WAIT)
                     && have_word && (op == CMD_CANCEL);

  assign trig_err = !halt && trigger && (state != S_TRIG_WAIT);
  assign uf_err   = !halt && cmd_buf_empty && (pair_rd || (wait_done && cont));
  assign go       = !halt && !trig_err && !uf_err;

  // Take a new command in IDLE or as the current one ends
  assign fetch = go && have_word && !cancel && (state == S_IDLE || wait_done);

  assign cmd_word_rd_en   = fetch || (go && have_word && (cancel || pair_rd));
  assign waiting_for_trig = (state == S_TRIG_WAIT);

  // Calibration goes straight to the table
  assign cal_wr  = fetch && (op == CMD_SET_CAL);
  assign cal_ch  = cmd_cal_ch(cmd_word);
  assign cal_val = cmd_cal_val(cmd_word);

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_IDLE;
    end else if (halt || trig_err || uf_err) begin
      state <= S_ERROR;  // Sticky until reset
    end else if (cancel) begin
      state <= S_IDLE;
    end else if (fetch) begin
      case (op)
        CMD_NO_OP:  state <= cmd_word[TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
        CMD_DAC_WR: state <= S_DAC_WR;
        default:    state <= S_IDLE;  // SET_CAL done, lone CANCEL ignored
      endcase
    end else if (wait_done) begin
      state <= S_IDLE;  // Buffer empty, no CONT
    end else if (state == S_DAC_WR && spi.pair_done && pair_idx == LAST_PAIR) begin
      state <= trig_mode ? S_TRIG_WAIT : S_DELAY;
    end
  end

  // Command flags and wait count
  always_ff @(posedge clk) begin
    if (!resetn) begin
      do_ldac   <= 1'b0;
      trig_mode <= 1'b0;
      cont      <= 1'b0;
      wait_cnt  <= '0;
    end else if (fetch && (op == CMD_NO_OP || op == CMD_DAC_WR)) begin
      do_ldac   <= cmd_word[LDAC_BIT];
      trig_mode <= cmd_word[TRIG_BIT];
      cont      <= cmd_word[CONT_BIT];
      wait_cnt  <= cmd_count(cmd_word);  // Held through the DAC writes
    end else if (wait_cnt != '0
                 && (state == S_DELAY || (state == S_TRIG_WAIT && trigger))) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Channel pairs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pair_rd  <= 1'b0;
      pair_idx <= '0;
    end else begin
      pair_rd <= 1'b0;
      if (fetch && op == CMD_DAC_WR) begin
        pair_rd  <= 1'b1;  // First pair right after the command word
        pair_idx <= '0;
      end else if (!halt && state == S_DAC_WR && spi.pair_done
                   && pair_idx != LAST_PAIR) begin
        pair_rd  <= 1'b1;
        pair_idx <= pair_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) pair.load <= 1'b0;
    else         pair.load <= pair_rd && have_word && go;
  end

  always_ff @(posedge clk) begin
    if (pair_rd) begin
      pair.raw_lo  <= cmd_word[15:0];   // Even channel in the low half
      pair.raw_hi  <= cmd_word[31:16];
      pair.base_ch <= {pair_idx, 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // LDAC and flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) ldac <= 1'b0;
    else         ldac <= go && wait_done && do_ldac && !cancel;  // Normal end only
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      unexp_trig        <= 1'b0;
      cmd_buf_underflow <= 1'b0;
    end else begin
      if (trig_err) unexp_trig        <= 1'b1;
      if (uf_err)   cmd_buf_underflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dac_code_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_code_calc
  import ad5676_pkg::*;
  import dac_cmd_pkg::*;
#(
  parameter int ABS_CAL_MAX = 4096  // Largest offset magnitude accepted
)(
  input  wire            clk,
  input  wire            resetn,

  input  wire            cal_wr,
  input  wire dac_chan_t cal_ch,
  input  wire cal_val_t  cal_val,
  input  wire            in_error,

  dac_pair_if.sink       pair,
  spi_pair_if.source     spi,

  output logic           cal_oob,
  output logic           dac_val_oob
);

  typedef logic signed [16:0] dac_sum_t;  // Signed code plus offset, one spare bit

  localparam dac_sum_t SUM_MAX = 17'sd32767;

  cal_val_t  cal_tab [8];
  logic      s1_valid;  // Sums ready
  dac_chan_t s1_ch;
  dac_sum_t  sum_lo;
  dac_sum_t  sum_hi;
  logic      raw_bad;
  logic      cal_bad;
  logic      sum_bad;

  // 0 maps to -32767, 32767 to zero
  function automatic dac_sum_t code_to_signed(dac_code_t code);
    return $signed({1'b0, code}) - $signed({1'b0, CODE_MIDSCALE});
  endfunction

  function automatic dac_code_t signed_to_code(dac_sum_t val);
    dac_sum_t shifted;
    shifted = val + $signed({1'b0, CODE_MIDSCALE});
    return shifted[15:0];
  endfunction

  assign raw_bad = (pair.raw_lo == CODE_FORBIDDEN) || (pair.raw_hi == CODE_FORBIDDEN);
  assign cal_bad = (cal_val > ABS_CAL_MAX) || (cal_val < -ABS_CAL_MAX);
  assign sum_bad = (sum_lo > SUM_MAX) || (sum_lo < -SUM_MAX)
                   || (sum_hi > SUM_MAX) || (sum_hi < -SUM_MAX);

  ////////////////////////////////////////////////////////////////////////////
  // Calibration table
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cal_tab <= '{default: '0};  // Zero offset on every channel
      cal_oob <= 1'b0;
    end else if (cal_wr) begin
      if (cal_bad) cal_oob         <= 1'b1;  // Old value kept
      else         cal_tab[cal_ch] <= cal_val;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Two-stage pipe, sum then check and pack
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) s1_valid <= 1'b0;
    else         s1_valid <= pair.load && !raw_bad && !in_error;
  end

  always_ff @(posedge clk) begin
    if (pair.load) begin
      sum_lo <= code_to_signed(pair.raw_lo) + cal_tab[pair.base_ch];
      sum_hi <= code_to_signed(pair.raw_hi) + cal_tab[pair.base_ch | 3'd1];
      s1_ch  <= pair.base_ch;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      spi.start   <= 1'b0;
      dac_val_oob <= 1'b0;
    end else begin
      spi.start <= s1_valid && !sum_bad && !in_error;  // Nothing sent on a bad pair
      if ((pair.load && raw_bad) || (s1_valid && sum_bad)) dac_val_oob <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      spi.word_a <= spi_write_word(s1_ch, signed_to_code(sum_lo));
      spi.word_b <= spi_write_word(s1_ch | 3'd1, signed_to_code(sum_hi));
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dac_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_ctrl_top
  import ad5676_pkg::*;
  import dac_cmd_pkg::*;
#(
  parameter int ABS_CAL_MAX = 4096
)(
  input  wire            clk,
  input  wire            resetn,

  // Command buffer, first word falls through
  output logic           cmd_word_rd_en,
  input  wire cmd_word_t cmd_word,
  input  wire            cmd_buf_empty,

  input  wire            trigger,
  output logic           waiting_for_trig,

  output logic           cal_oob,
  output logic           dac_val_oob,
  output logic           unexp_trig,
  output logic           cmd_buf_underflow,

  output logic           n_cs,
  output logic           mosi,
  output logic           ldac
);

  dac_pair_if pair_bus ();
  spi_pair_if spi_bus ();

  logic      cal_wr;
  dac_chan_t cal_ch;
  cal_val_t  cal_val;
  logic      calc_err;
  logic      any_err;

  // Flags are sticky, so their OR marks the error state everywhere
  assign calc_err = cal_oob || dac_val_oob;
  assign any_err  = calc_err || unexp_trig || cmd_buf_underflow;

  dac_cmd_sequencer u_seq (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .trigger           (trigger),
    .waiting_for_trig  (waiting_for_trig),
    .ldac              (ldac),
    .unexp_trig        (unexp_trig),
    .cmd_buf_underflow (cmd_buf_underflow),
    .err_in            (calc_err),
    .cal_wr            (cal_wr),
    .cal_ch            (cal_ch),
    .cal_val           (cal_val),
    .pair              (pair_bus.source),
    .spi               (spi_bus.monitor)
  );

  dac_code_calc #(
    .ABS_CAL_MAX (ABS_CAL_MAX)
  ) u_calc (
    .clk         (clk),
    .resetn      (resetn),
    .cal_wr      (cal_wr),
    .cal_ch      (cal_ch),
    .cal_val     (cal_val),
    .in_error    (any_err),
    .pair        (pair_bus.sink),
    .spi         (spi_bus.source),
    .cal_oob     (cal_oob),
    .dac_val_oob (dac_val_oob)
  );

  ad5676_spi_writer u_spi (
    .clk      (clk),
    .resetn   (resetn),
    .in_error (any_err),
    .spi      (spi_bus.sink),
    .n_cs     (n_cs),
    .mosi     (mosi)
  );

endmodule

`default_nettype wire

// ==== rtl/dac_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Sequencer to calculator, one channel pair
////////////////////////////////////////////////////////////////////////////

interface dac_pair_if
  import ad5676_pkg::*;
();
  logic      load;     // One-cycle strobe
  dac_code_t raw_lo;   // Even channel code
  dac_code_t raw_hi;   // Odd channel code
  dac_chan_t base_ch;  // Even channel index

  modport source (output load, raw_lo, raw_hi, base_ch);
  modport sink   (input  load, raw_lo, raw_hi, base_ch);
endinterface

////////////////////////////////////////////////////////////////////////////
// Calculator to SPI writer, two frames per start
////////////////////////////////////////////////////////////////////////////

interface spi_pair_if
  import ad5676_pkg::*;
();
  logic      start;      // One-cycle strobe, words valid
  spi_word_t word_a;     // Sent first
  spi_word_t word_b;
  logic      pair_done;  // Pulses as n_cs rises after word_b

  modport source  (output start, word_a, word_b);
  modport sink    (input  start, word_a, word_b, output pair_done);
  modport monitor (input  pair_done);
endinterface

`default_nettype wire

// ==== testbench/dac_ctrl_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_ctrl_props (
  input wire clk,
  input wire resetn,
  input wire n_cs,
  input wire mosi,
  input wire ldac,
  input wire cmd_word_rd_en,
  input wire in_error  // Any sticky flag set
);

  // Data line parked low between frames
  a_mosi_quiet: assert property (@(posedge clk) disable iff (!resetn) n_cs |-> !mosi)
    else $error("mosi high while n_cs is high");

  // Load strobe is a single cycle
  a_ldac_pulse: assert property (@(posedge clk) disable iff (!resetn) ldac |=> !ldac)
    else $error("ldac held longer than one cycle");

  // Error parks the SPI pins, ldac and the command reads, then they stay parked
  a_err_parked: assert property (@(posedge clk) disable iff (!resetn)
                                 in_error |=> n_cs && !mosi && !ldac && !cmd_word_rd_en)
    else $error("n_cs, mosi, ldac or cmd_word_rd_en active in the error state");

endmodule

bind dac_ctrl_top dac_ctrl_props i_props (
  .clk            (clk),
  .resetn         (resetn),
  .n_cs           (n_cs),
  .mosi           (mosi),
  .ldac           (ldac),
  .cmd_word_rd_en (cmd_word_rd_en),
  .in_error       (any_err)
);

`default_nettype wire

// ==== testbench/tb_dac_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dac_ctrl
  import ad5676_pkg::*;
  import dac_cmd_pkg::*;
();

  localparam int ABS_CAL_MAX  = 4096;
  localparam int N_SEQ        = 10;  // Commands in the random sequence
  localparam int MAX_DELAY    = 40;
  localparam int MAX_TRIG     = 3;
  localparam int PAIR_CYCLES  = 2 * (CS_GAP_CYCLES + SPI_BITS) + 6;  // Two frames plus pipe
  localparam int CMD_CYCLES   = PAIRS_PER_WRITE * PAIR_CYCLES + MAX_DELAY + 8 * (MAX_TRIG + 1);
  localparam int WATCH_CYCLES = (N_SEQ + 8) * CMD_CYCLES + 1000;  // All phases plus margin

  logic      clk;
  logic      resetn;
  logic      cmd_word_rd_en;
  cmd_word_t cmd_word;
  logic      cmd_buf_empty;
  logic      trigger;
  logic      waiting_for_trig;
  logic      cal_oob;
  logic      dac_val_oob;
  logic      unexp_trig;
  logic      cmd_buf_underflow;
  logic      n_cs;
  logic      mosi;
  logic      ldac;

  cmd_word_t cmd_q [$];  // Command buffer contents, head is on cmd_word
  spi_word_t exp_q [$];  // Frames the model predicts
  spi_word_t got_q [$];  // Frames seen on mosi
  int        cal_m [8];  // Model of the calibration table
  int        err_val;
  int        err_other;
  int        ldac_seen;
  int        trig_seen;
  int        bits;
  spi_word_t sr;
  logic      trig_en;    // Random triggers allowed
  logic      trig_req;   // One forced trigger

  dac_ctrl_top #(.ABS_CAL_MAX(ABS_CAL_MAX)) i_dut (.*);

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Bus models and monitors
  ////////////////////////////////////////////////////////////////////////////

  // First-word-fall-through buffer, pop on rd_en seen at the edge
  always @(posedge clk) begin
    if (cmd_word_rd_en && cmd_q.size() != 0) cmd_q.delete(0);
    cmd_buf_empty <= (cmd_q.size() == 0);
    cmd_word      <= (cmd_q.size() != 0) ? cmd_q[0] : '0;
  end

  // Pulses never back to back, so a wait cannot end under a pending pulse
  always @(posedge clk) begin
    if (!resetn) begin
      trigger <= 1'b0;
    end else if (trig_req) begin
      trigger <= 1'b1;
      trig_req = 1'b0;
    end else if (trig_en && waiting_for_trig && !trigger && $urandom_range(2, 0) == 0) begin
      trigger <= 1'b1;
      trig_seen++;
    end else begin
      trigger <= 1'b0;
    end
  end

  // Frame capture, MSB first, sampled mid cycle
  always @(negedge clk) begin
    if (!resetn || n_cs) begin
      bits = 0;  // Aborted frames are dropped
    end else begin
      sr = {sr[SPI_BITS-2:0], mosi};
      bits++;
      if (bits == SPI_BITS) begin
        got_q.push_back(sr);
        bits = 0;
      end
    end
    if (ldac) ldac_seen++;
  end

  initial begin
    repeat (WATCH_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCH_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_frame(spi_word_t got, spi_word_t exp);
    if (got !== exp) begin
      err_val++;
      $display("[ERROR] %0t mosi frame: got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      err_val++;
      $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      err_val++;
      $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Model and stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic cmd_word_t make_cmd(cmd_op_e op, bit trig, bit cont, bit ld, wait_cnt_t n);
    return {op, trig, cont, ld, 1'b0, n};
  endfunction

  // Signed value plus offset, back to offset binary, is raw plus offset
  function automatic spi_word_t expect_frame(dac_chan_t ch, dac_code_t raw);
    int code;
    code = int'(raw) + cal_m[ch];
    return {SPI_CMD_WRITE, 1'b0, ch, code[15:0]};
  endfunction

  // Command word, four pair words, eight predicted frames
  task automatic push_dac_wr(bit trig, bit cont, bit ld, wait_cnt_t n, int lim);
    dac_code_t lo;
    dac_code_t hi;
    cmd_q.push_back(make_cmd(CMD_DAC_WR, trig, cont, ld, n));
    for (int p = 0; p < PAIRS_PER_WRITE; p++) begin
      lo = dac_code_t'($urandom_range(65534 - lim, lim));
      hi = dac_code_t'($urandom_range(65534 - lim, lim));
      cmd_q.push_back({hi, lo});  // Even channel in the low half
      exp_q.push_back(expect_frame(dac_chan_t'(2 * p), lo));
      exp_q.push_back(expect_frame(dac_chan_t'(2 * p + 1), hi));
    end
  endtask

  task automatic wait_trig_level(logic level, int limit);
    int t;
    t = 0;
    while (waiting_for_trig !== level && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (waiting_for_trig !== level) begin
      err_other++;
      $display("Timeout: waiting_for_trig never went to %b", level);
    end
  endtask

  // Buffer empty, last pair out, last wait over
  task automatic drain();
    int t;
    t = 0;
    while (cmd_q.size() != 0 && t < N_SEQ * CMD_CYCLES) begin
      @(negedge clk);
      t++;
    end
    if (cmd_q.size() != 0) begin
      err_other++;
      $display("Timeout: command buffer still holds %0d words", cmd_q.size());
    end
    repeat (PAIR_CYCLES + 8) @(negedge clk);
    wait_trig_level(1'b0, 200);
    repeat (MAX_DELAY + 8) @(negedge clk);
  endtask

  task automatic compare_frame_queues();
    check_count("frame count", got_q.size(), exp_q.size());
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) check_frame(got_q[i], exp_q[i]);
    got_q.delete();
    exp_q.delete();
  endtask

  task automatic apply_reset();
    @(posedge clk);
    resetn <= 1'b0;
    cmd_q.delete();
    got_q.delete();
    exp_q.delete();
    foreach (cal_m[i]) cal_m[i] = 0;  // Table resets to zero
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    ldac_seen = 0;
    trig_seen = 0;
  endtask

  // Only flag number `which` set, writer parked
  task automatic expect_single_error(int which);
    int t;
    t = 0;
    while (!(cal_oob || dac_val_oob || unexp_trig || cmd_buf_underflow) && t < 100) begin
      @(negedge clk);
      t++;
    end
    if (t == 100) begin
      err_other++;
      $display("Timeout: no error flag rose in error case %0d", which);
    end
    repeat (4) @(negedge clk);
    check_flag("cal_oob", cal_oob, which == 0);
    check_flag("dac_val_oob", dac_val_oob, which == 1);
    check_flag("unexp_trig", unexp_trig, which == 2);
    check_flag("cmd_buf_underflow", cmd_buf_underflow, which == 3);
    check_flag("n_cs", n_cs, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bit        trig;
    bit        ld;
    bit        cont;
    wait_cnt_t n;
    int        off;
    int        exp_ldac;
    int        exp_trig;
    clk           = 1'b0;
    resetn        = 1'b0;
    cmd_word      = '0;
    cmd_buf_empty = 1'b1;
    trigger       = 1'b0;
    err_val       = 0;
    err_other     = 0;
    trig_en       = 1'b1;
    trig_req      = 1'b0;
    void'($urandom(90));
    apply_reset();

    // Zero calibration, frames carry the raw codes
    @(negedge clk);
    push_dac_wr(1'b0, 1'b0, 1'b0, 26'd2, 0);
    drain();
    compare_frame_queues();

    // Offsets on every channel, then a write that stays in range
    @(negedge clk);
    for (int ch = 0; ch < 8; ch++) begin
      off       = int'($urandom_range(2 * ABS_CAL_MAX, 0)) - ABS_CAL_MAX;
      cal_m[ch] = off;
      cmd_q.push_back({CMD_SET_CAL, 11'd0, 3'(ch), 16'(off)});
    end
    push_dac_wr(1'b0, 1'b0, 1'b1, 26'd3, ABS_CAL_MAX);
    drain();
    compare_frame_queues();

    // Random NO_OP and DAC_WR mix
    @(posedge clk);
    ldac_seen = 0;
    trig_seen = 0;
    exp_ldac  = 0;
    exp_trig  = 0;
    @(negedge clk);
    for (int i = 0; i < N_SEQ; i++) begin
      trig = 1'($urandom_range(1, 0));
      ld   = 1'($urandom_range(1, 0));
      cont = (i < N_SEQ - 1) && 1'($urandom_range(1, 0));
      n    = trig ? wait_cnt_t'($urandom_range(MAX_TRIG, 0))
                  : wait_cnt_t'($urandom_range(MAX_DELAY, 1));  // Delay 0 would abut ldac
      if (ld) exp_ldac++;
      if (trig) exp_trig += int'(n) + 1;  // Driver only pulses while waiting_for_trig
      if ($urandom_range(1, 0) == 1) push_dac_wr(trig, cont, ld, n, ABS_CAL_MAX);
      else cmd_q.push_back(make_cmd(CMD_NO_OP, trig, cont, ld, n));
    end
    drain();
    compare_frame_queues();
    check_count("ldac pulses", ldac_seen, exp_ldac);
    check_count("trigger pulses", trig_seen, exp_trig);

    // Cancel a trigger wait, next command still ends with ldac
    @(posedge clk);
    ldac_seen = 0;
    trig_en   = 1'b0;
    @(negedge clk);
    cmd_q.push_back(make_cmd(CMD_NO_OP, 1'b1, 1'b0, 1'b1, 26'd2));
    wait_trig_level(1'b1, 50);
    repeat (3) @(negedge clk);
    cmd_q.push_back(make_cmd(CMD_CANCEL, 1'b0, 1'b0, 1'b0, '0));
    cmd_q.push_back(make_cmd(CMD_NO_OP, 1'b0, 1'b0, 1'b1, 26'd5));
    drain();
    check_count("ldac pulses around cancel", ldac_seen, 1);
    trig_en = 1'b1;

    // Error cases, fresh reset each
    apply_reset();
    @(negedge clk);
    cmd_q.push_back({CMD_SET_CAL, 11'd0, 3'd5, 16'(ABS_CAL_MAX + 1 + $urandom_range(1000, 0))});
    expect_single_error(0);

    apply_reset();
    @(negedge clk);
    cmd_q.push_back(make_cmd(CMD_DAC_WR, 1'b0, 1'b0, 1'b0, '0));
    cmd_q.push_back({16'h1234, CODE_FORBIDDEN});
    expect_single_error(1);

    apply_reset();
    @(negedge clk);
    trig_req = 1'b1;  // Lands in IDLE
    expect_single_error(2);

    apply_reset();
    @(negedge clk);
    cmd_q.push_back(make_cmd(CMD_NO_OP, 1'b0, 1'b1, 1'b0, 26'd2));  // Nothing follows
    expect_single_error(3);

    $display("Errors: %0d value mismatches, %0d other failures", err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
